// File: verilog/mac_rx_pkg.sv
// XGMII control characters, Ethernet and MAC control frame constants, datapath types
`default_nettype none

package mac_rx_pkg;

    // Datapath geometry
    localparam int data_w = 32;
    localparam int keep_w = data_w / 8;

    typedef logic [data_w-1:0] data_t;
    typedef logic [keep_w-1:0] keep_t;
    typedef logic [15:0]       quanta_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // XGMII control characters
    localparam logic [7:0] xgmii_idle  = 8'h07;
    localparam logic [7:0] xgmii_start = 8'hFB;
    localparam logic [7:0] xgmii_term  = 8'hFD;
    localparam logic [7:0] xgmii_error = 8'hFE;

    // Preamble and start of frame delimiter
    localparam logic [7:0] eth_preamble = 8'h55;
    localparam logic [7:0] eth_sfd      = 8'hD5;

    // CRC register value after a good frame and its FCS, reflected, not inverted
    localparam logic [31:0] crc_residue = 32'hDEBB20E3;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // MAC control frames (802.3 annex 31B)
    localparam logic [47:0] mcf_eth_dst  = 48'h01_80_C2_00_00_01;
    localparam logic [15:0] mcf_eth_type = 16'h8808;
    localparam logic [15:0] lfc_opcode   = 16'h0001;

endpackage

`default_nettype wire

// File: verilog/xgmii_rx_decode.sv
// XGMII receive decoder: start and SFD detection, terminate handling, byte stream out
`timescale 1ns/1ps
`default_nettype none

module xgmii_rx_decode (
    input  wire logic              rx_clk,
    input  wire logic              rx_rst,
    input  wire mac_rx_pkg::data_t xgmii_rxd,
    input  wire mac_rx_pkg::keep_t xgmii_rxc,
    output mac_rx_pkg::data_t      dec_data,
    output mac_rx_pkg::keep_t      dec_keep,
    output logic                   dec_valid,
    output logic                   dec_last,
    output logic                   dec_err,
    output logic                   start_packet
);

    localparam int lane_w = $clog2(mac_rx_pkg::keep_w);

    typedef enum logic [1:0] {
        st_idle,
        st_sfd,
        st_data
    } state_t;

    state_t state;

    // Lane scan of the incoming word
    logic              end_found;
    logic              end_idle;
    logic [lane_w-1:0] end_lane;
    mac_rx_pkg::keep_t word_keep;
    logic              word_err;
    logic              term0;

    // First pipeline stage, one word behind the input
    mac_rx_pkg::data_t s1_data;
    mac_rx_pkg::keep_t s1_keep;
    logic              s1_valid;
    logic              s1_term;
    logic              s1_err;
    logic              err_acc;
    logic              last_now;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Find the lowest lane that ends the frame
    always_comb begin
        end_found = 1'b0;
        end_idle  = 1'b0;
        end_lane  = '0;
        for (int i = mac_rx_pkg::keep_w - 1; i >= 0; i--) begin
            if (xgmii_rxc[i] && (xgmii_rxd[8*i +: 8] == mac_rx_pkg::xgmii_term ||
                                 xgmii_rxd[8*i +: 8] == mac_rx_pkg::xgmii_idle)) begin
                end_found = 1'b1;
                end_lane  = lane_w'(i);
                // Idle without terminate cuts the frame short
                end_idle  = xgmii_rxd[8*i +: 8] == mac_rx_pkg::xgmii_idle;
            end
        end
        word_keep = '0;
        word_err  = end_idle;
        for (int i = 0; i < mac_rx_pkg::keep_w; i++) begin
            if (!end_found || i < end_lane) begin
                word_keep[i] = 1'b1;
                word_err     = word_err | xgmii_rxc[i];
            end
        end
    end

    // Terminate in lane 0 closes the word already in stage 1
    assign term0    = (state == st_data) && end_found && (end_lane == '0);
    assign last_now = s1_valid && (s1_term || term0);

    always_ff @(posedge rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            state        <= st_idle;
            start_packet <= 1'b0;
            s1_valid     <= 1'b0;
            s1_term      <= 1'b0;
            err_acc      <= 1'b0;
            dec_valid    <= 1'b0;
            dec_last     <= 1'b0;
            dec_err      <= 1'b0;
        end else begin
            start_packet <= 1'b0;
            s1_valid     <= 1'b0;
            s1_term      <= 1'b0;

            case (state)
                st_idle: begin
                    if (xgmii_rxc == mac_rx_pkg::keep_t'(1) &&
                        xgmii_rxd == {{3{mac_rx_pkg::eth_preamble}},
                                      mac_rx_pkg::xgmii_start}) begin
                        state        <= st_sfd;
                        start_packet <= 1'b1;
                    end
                end
                st_sfd: begin
                    if (xgmii_rxc == '0 &&
                        xgmii_rxd == {mac_rx_pkg::eth_sfd,
                                      {3{mac_rx_pkg::eth_preamble}}}) begin
                        state <= st_data;
                    end else begin
                        state <= st_idle;
                    end
                end
                st_data: begin
                    s1_valid <= |word_keep;
                    s1_term  <= end_found;
                    if (end_found) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase

            // Output stage
            dec_valid <= s1_valid;
            dec_last  <= last_now;
            dec_err   <= last_now && (err_acc || s1_err || (term0 && word_err));
            if (s1_valid) begin
                err_acc <= last_now ? 1'b0 : (err_acc | s1_err);
            end
        end
    end

    always_ff @(posedge rx_clk) begin
        s1_data  <= xgmii_rxd;
        s1_keep  <= word_keep;
        s1_err   <= word_err;
        dec_data <= s1_data;
        dec_keep <= s1_keep;
    end

endmodule

`default_nettype wire

// File: verilog/rx_fcs_check.sv
// CRC-32 FCS check on the decoded stream, error tagging of the last beat
`timescale 1ns/1ps
`default_nettype none

module rx_fcs_check (
    input  wire logic              rx_clk,
    input  wire logic              rx_rst,
    input  wire mac_rx_pkg::data_t dec_data,
    input  wire mac_rx_pkg::keep_t dec_keep,
    input  wire logic              dec_valid,
    input  wire logic              dec_last,
    input  wire logic              dec_err,
    output mac_rx_pkg::data_t      m_axis_rx_tdata,
    output mac_rx_pkg::keep_t      m_axis_rx_tkeep,
    output logic                   m_axis_rx_tvalid,
    output logic                   m_axis_rx_tlast,
    output logic                   m_axis_rx_tuser,
    output logic                   error_bad_frame,
    output logic                   error_bad_fcs
);

    // Reflected Ethernet polynomial
    localparam logic [31:0] crc_poly = 32'hEDB88320;

    logic [31:0] crc_state;
    logic [31:0] crc_next;
    logic        fcs_bad;
    logic        frame_end;

    // One byte through the CRC, LSB first
    function automatic logic [31:0] crc_byte(logic [31:0] crc, logic [7:0] b);
        logic [31:0] c;
        c = crc ^ {24'd0, b};
        for (int k = 0; k < 8; k++) begin
            c = c[0] ? ((c >> 1) ^ crc_poly) : (c >> 1);
        end
        return c;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Keep is contiguous from lane 0, so lanes go in order
    always_comb begin
        crc_next = crc_state;
        for (int i = 0; i < mac_rx_pkg::keep_w; i++) begin
            if (dec_keep[i]) begin
                crc_next = crc_byte(crc_next, dec_data[8*i +: 8]);
            end
        end
    end

    assign fcs_bad   = crc_next != mac_rx_pkg::crc_residue;
    assign frame_end = dec_valid && dec_last;

    always_ff @(posedge rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            crc_state        <= '1;
            m_axis_rx_tvalid <= 1'b0;
            m_axis_rx_tlast  <= 1'b0;
            m_axis_rx_tuser  <= 1'b0;
            error_bad_frame  <= 1'b0;
            error_bad_fcs    <= 1'b0;
        end else begin
            if (dec_valid) begin
                // Reseed for the next frame
                crc_state <= dec_last ? '1 : crc_next;
            end
            m_axis_rx_tvalid <= dec_valid;
            m_axis_rx_tlast  <= frame_end;
            m_axis_rx_tuser  <= frame_end && (dec_err || fcs_bad);
            // Decode error wins over FCS
            error_bad_frame  <= frame_end && dec_err;
            error_bad_fcs    <= frame_end && !dec_err && fcs_bad;
        end
    end

    always_ff @(posedge rx_clk) begin
        m_axis_rx_tdata <= dec_data;
        m_axis_rx_tkeep <= dec_keep;
    end

endmodule

`default_nettype wire

// File: verilog/mcf_rx_parse.sv
// MAC control frame header capture and PAUSE frame recognition
`timescale 1ns/1ps
`default_nettype none

module mcf_rx_parse (
    input  wire logic              rx_clk,
    input  wire logic              rx_rst,
    input  wire mac_rx_pkg::data_t m_axis_rx_tdata,
    input  wire mac_rx_pkg::keep_t m_axis_rx_tkeep,
    input  wire logic              m_axis_rx_tvalid,
    input  wire logic              m_axis_rx_tlast,
    input  wire logic              m_axis_rx_tuser,
    output logic                   lfc_valid,
    output mac_rx_pkg::quanta_t    lfc_quanta,
    output logic                   stat_rx_mcf
);

    // Beat 4 carries the quanta, beat 5 and beyond carry nothing of interest
    localparam logic [2:0] beat_max = 3'd5;

    logic [2:0]  beat_cnt;
    logic [47:0] dst_r;
    logic [15:0] type_r;
    logic [15:0] opcode_r;
    logic        hdr_seen;
    logic        is_mcf;

    // First byte on the wire sits in lane 0
    function automatic logic [15:0] swap16(logic [15:0] x);
        return {x[7:0], x[15:8]};
    endfunction

    function automatic logic [31:0] swap32(logic [31:0] x);
        return {x[7:0], x[15:8], x[23:16], x[31:24]};
    endfunction

    // Quanta bytes are at offsets 16 and 17, lanes 0 and 1 of beat 4
    assign hdr_seen = (beat_cnt == beat_max) || (beat_cnt == 3'd4 && m_axis_rx_tkeep[1]);
    assign is_mcf   = hdr_seen && !m_axis_rx_tuser &&
                      dst_r == mac_rx_pkg::mcf_eth_dst &&
                      type_r == mac_rx_pkg::mcf_eth_type;

    always_ff @(posedge rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            beat_cnt    <= '0;
            stat_rx_mcf <= 1'b0;
            lfc_valid   <= 1'b0;
        end else begin
            stat_rx_mcf <= 1'b0;
            lfc_valid   <= 1'b0;
            if (m_axis_rx_tvalid) begin
                if (m_axis_rx_tlast) begin
                    beat_cnt    <= '0;
                    stat_rx_mcf <= is_mcf;
                    lfc_valid   <= is_mcf && opcode_r == mac_rx_pkg::lfc_opcode;
                end else if (beat_cnt != beat_max) begin
                    beat_cnt <= beat_cnt + 3'd1;
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Header fields by beat
    always_ff @(posedge rx_clk) begin
        if (m_axis_rx_tvalid) begin
            case (beat_cnt)
                3'd0: dst_r[47:16] <= swap32(m_axis_rx_tdata);
                3'd1: dst_r[15:0]  <= swap16(m_axis_rx_tdata[15:0]);
                3'd3: begin
                    type_r   <= swap16(m_axis_rx_tdata[15:0]);
                    opcode_r <= swap16(m_axis_rx_tdata[31:16]);
                end
                3'd4: lfc_quanta <= swap16(m_axis_rx_tdata[15:0]);
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/lfc_pause_rx.sv
// Receive PAUSE timer with four-phase rx_lfc_req/ack handshake and statistics
`timescale 1ns/1ps
`default_nettype none

module lfc_pause_rx #(
    parameter int quanta_cycles = 16
) (
    input  wire logic                rx_clk,
    input  wire logic                rx_rst,
    input  wire logic                lfc_valid,
    input  wire mac_rx_pkg::quanta_t lfc_quanta,
    input  wire logic                cfg_rx_lfc_en,
    output logic                     rx_lfc_req,
    input  wire logic                rx_lfc_ack,
    output logic                     stat_rx_lfc_pkt,
    output logic                     stat_rx_lfc_xon,
    output logic                     stat_rx_lfc_xoff,
    output logic                     stat_rx_lfc_paused
);

    localparam int presc_w = $clog2(quanta_cycles + 1);

    mac_rx_pkg::quanta_t quanta_cnt;
    mac_rx_pkg::quanta_t cnt_next;
    logic [presc_w-1:0]  presc;
    logic [presc_w-1:0]  presc_next;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Quanta counter, a new PAUSE overrides the running one
    always_comb begin
        cnt_next   = quanta_cnt;
        presc_next = presc;
        if (lfc_valid && cfg_rx_lfc_en) begin
            cnt_next   = lfc_quanta;
            presc_next = '0;
        end else if (quanta_cnt != '0) begin
            if (presc == presc_w'(quanta_cycles - 1)) begin
                presc_next = '0;
                cnt_next   = quanta_cnt - 1'b1;
            end else begin
                presc_next = presc + 1'b1;
            end
        end
    end

    always_ff @(posedge rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            quanta_cnt         <= '0;
            presc              <= '0;
            rx_lfc_req         <= 1'b0;
            stat_rx_lfc_pkt    <= 1'b0;
            stat_rx_lfc_xon    <= 1'b0;
            stat_rx_lfc_xoff   <= 1'b0;
            stat_rx_lfc_paused <= 1'b0;
        end else begin
            quanta_cnt <= cnt_next;
            presc      <= presc_next;

            // New request waits until the user has dropped ack
            if (cnt_next == '0) begin
                rx_lfc_req <= 1'b0;
            end else if (!rx_lfc_ack) begin
                rx_lfc_req <= 1'b1;
            end

            // Statistics count even with pausing disabled
            stat_rx_lfc_pkt    <= lfc_valid;
            stat_rx_lfc_xon    <= lfc_valid && lfc_quanta == '0;
            stat_rx_lfc_xoff   <= lfc_valid && lfc_quanta != '0;
            stat_rx_lfc_paused <= rx_lfc_req && rx_lfc_ack;
        end
    end

endmodule

`default_nettype wire

// File: verilog/eth_mac_rx.sv
// 10G Ethernet MAC receive top level: XGMII decoder, FCS check, control frame parser, pause
`timescale 1ns/1ps
`default_nettype none

module eth_mac_rx (
    input  wire logic              rx_clk,
    input  wire logic              rx_rst,

    // XGMII from the PHY
    input  wire mac_rx_pkg::data_t xgmii_rxd,
    input  wire mac_rx_pkg::keep_t xgmii_rxc,

    // Receive stream, no back-pressure
    output wire mac_rx_pkg::data_t m_axis_rx_tdata,
    output wire mac_rx_pkg::keep_t m_axis_rx_tkeep,
    output wire logic              m_axis_rx_tvalid,
    output wire logic              m_axis_rx_tlast,
    output wire logic              m_axis_rx_tuser,

    // PAUSE handshake
    input  wire logic              cfg_rx_lfc_en,
    output wire logic              rx_lfc_req,
    input  wire logic              rx_lfc_ack,

    // Status
    output wire logic              rx_start_packet,
    output wire logic              rx_error_bad_frame,
    output wire logic              rx_error_bad_fcs,
    output wire logic              stat_rx_mcf,
    output wire logic              stat_rx_lfc_pkt,
    output wire logic              stat_rx_lfc_xon,
    output wire logic              stat_rx_lfc_xoff,
    output wire logic              stat_rx_lfc_paused
);

    // One pause quantum is 512 bit times
    localparam int quanta_cycles = 512 / mac_rx_pkg::data_w;

    mac_rx_pkg::data_t   dec_data;
    mac_rx_pkg::keep_t   dec_keep;
    logic                dec_valid;
    logic                dec_last;
    logic                dec_err;
    logic                lfc_valid;
    mac_rx_pkg::quanta_t lfc_quanta;

    xgmii_rx_decode u_decode (
        .rx_clk       (rx_clk),
        .rx_rst       (rx_rst),
        .xgmii_rxd    (xgmii_rxd),
        .xgmii_rxc    (xgmii_rxc),
        .dec_data     (dec_data),
        .dec_keep     (dec_keep),
        .dec_valid    (dec_valid),
        .dec_last     (dec_last),
        .dec_err      (dec_err),
        .start_packet (rx_start_packet)
    );

    rx_fcs_check u_fcs (
        .rx_clk           (rx_clk),
        .rx_rst           (rx_rst),
        .dec_data         (dec_data),
        .dec_keep         (dec_keep),
        .dec_valid        (dec_valid),
        .dec_last         (dec_last),
        .dec_err          (dec_err),
        .m_axis_rx_tdata  (m_axis_rx_tdata),
        .m_axis_rx_tkeep  (m_axis_rx_tkeep),
        .m_axis_rx_tvalid (m_axis_rx_tvalid),
        .m_axis_rx_tlast  (m_axis_rx_tlast),
        .m_axis_rx_tuser  (m_axis_rx_tuser),
        .error_bad_frame  (rx_error_bad_frame),
        .error_bad_fcs    (rx_error_bad_fcs)
    );

    // Parser taps the output stream, every frame is still forwarded
    mcf_rx_parse u_parse (
        .rx_clk           (rx_clk),
        .rx_rst           (rx_rst),
        .m_axis_rx_tdata  (m_axis_rx_tdata),
        .m_axis_rx_tkeep  (m_axis_rx_tkeep),
        .m_axis_rx_tvalid (m_axis_rx_tvalid),
        .m_axis_rx_tlast  (m_axis_rx_tlast),
        .m_axis_rx_tuser  (m_axis_rx_tuser),
        .lfc_valid        (lfc_valid),
        .lfc_quanta       (lfc_quanta),
        .stat_rx_mcf      (stat_rx_mcf)
    );

    lfc_pause_rx #(
        .quanta_cycles (quanta_cycles)
    ) u_pause (
        .rx_clk             (rx_clk),
        .rx_rst             (rx_rst),
        .lfc_valid          (lfc_valid),
        .lfc_quanta         (lfc_quanta),
        .cfg_rx_lfc_en      (cfg_rx_lfc_en),
        .rx_lfc_req         (rx_lfc_req),
        .rx_lfc_ack         (rx_lfc_ack),
        .stat_rx_lfc_pkt    (stat_rx_lfc_pkt),
        .stat_rx_lfc_xon    (stat_rx_lfc_xon),
        .stat_rx_lfc_xoff   (stat_rx_lfc_xoff),
        .stat_rx_lfc_paused (stat_rx_lfc_paused)
    );

endmodule

`default_nettype wire

// File: test/eth_mac_rx_assert.sv
// Concurrent assertions on the receive stream and the pause handshake, bound to eth_mac_rx
`timescale 1ns/1ps
`default_nettype none

module eth_mac_rx_assert (
    input wire logic       rx_clk,
    input wire logic       rx_rst,
    input wire logic [3:0] m_axis_rx_tkeep,
    input wire logic       m_axis_rx_tvalid,
    input wire logic       rx_lfc_req,
    input wire logic       rx_lfc_ack
);

    // Four-phase rule, a new request only after ack has dropped
    req_rise_ack_low: assert property (
        @(posedge rx_clk) disable iff (rx_rst)
        $rose(rx_lfc_req) |-> !$past(rx_lfc_ack)
    ) else $error("rx_lfc_req rose while rx_lfc_ack was high");

    valid_keep_nonzero: assert property (
        @(posedge rx_clk) disable iff (rx_rst)
        m_axis_rx_tvalid |-> m_axis_rx_tkeep != 4'b0000
    ) else $error("valid beat with empty tkeep");

    no_valid_in_reset: assert property (
        @(posedge rx_clk) rx_rst |-> !m_axis_rx_tvalid
    ) else $error("tvalid high during reset");

endmodule

bind eth_mac_rx eth_mac_rx_assert u_assert (.*);

`default_nettype wire

// File: test/tb_eth_mac_rx.sv
// Trace-driven testbench for eth_mac_rx: clock, reset, frame stimulus, beat and status checks
`timescale 1ns/1ps
`default_nettype none

module tb_eth_mac_rx;

    logic        rx_clk;
    logic        rx_rst;
    logic [31:0] xgmii_rxd;
    logic [3:0]  xgmii_rxc;
    logic        cfg_rx_lfc_en;
    logic        rx_lfc_ack;
    wire  [31:0] m_axis_rx_tdata;
    wire  [3:0]  m_axis_rx_tkeep;
    wire         m_axis_rx_tvalid;
    wire         m_axis_rx_tlast;
    wire         m_axis_rx_tuser;
    wire         rx_lfc_req;
    wire         rx_start_packet;
    wire         rx_error_bad_frame;
    wire         rx_error_bad_fcs;
    wire         stat_rx_mcf;
    wire         stat_rx_lfc_pkt;
    wire         stat_rx_lfc_xon;
    wire         stat_rx_lfc_xoff;
    wire         stat_rx_lfc_paused;

    integer      seed = 32'he3a5;
    int          err_count = 0;
    int          beat_count = 0;
    int          cyc = 0;
    int          limit = 1000000;
    int          last_end = 0;
    int          start_ref = 0;
    logic        prev_req = 1'b0;
    logic [31:0] mask;

    // Trace commands, expected beats and expected pause windows
    byte         cmd_q[$];
    int          a_q[$];
    int          b_q[$];
    int          c_q[$];
    logic [7:0]  frame_q[$];
    logic [31:0] exp_data[$];
    logic [3:0]  exp_keep[$];
    logic        exp_last[$];
    logic        exp_user[$];
    int          req_min[$];
    int          req_max[$];

    // Expected and seen status pulse counts
    int          exp_start = 0;
    int          exp_fcs = 0;
    int          exp_frame = 0;
    int          exp_mcf = 0;
    int          exp_xon = 0;
    int          exp_xoff = 0;
    int          n_start = 0;
    int          n_fcs = 0;
    int          n_frame = 0;
    int          n_mcf = 0;
    int          n_pkt = 0;
    int          n_xon = 0;
    int          n_xoff = 0;
    int          n_paused = 0;

    eth_mac_rx u_dut (.*);

    always #2 rx_clk = ~rx_clk;

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("error %s: expected %h, actual %h", name, exp, act);
            err_count++;
        end
    endtask

    // Bit-serial CRC-32 of frame_q, complemented, as sent on the wire
    function automatic logic [31:0] fcs_of();
        logic [31:0] c;
        logic        fb;
        c = 32'hFFFFFFFF;
        foreach (frame_q[i]) begin
            for (int k = 0; k < 8; k++) begin
                fb = c[0] ^ frame_q[i][k];
                c  = c >> 1;
                if (fb) c = c ^ 32'hEDB88320;
            end
        end
        return ~c;
    endfunction

    task automatic drive_word(input logic [31:0] d, input logic [3:0] c);
        @(posedge rx_clk);
        #1;
        xgmii_rxd = d;
        xgmii_rxc = c;
    endtask

    task automatic send_frame(input byte kind);
        logic [31:0] crc;
        logic [31:0] d;
        logic [3:0]  c;
        logic [3:0]  k;
        int          n;
        int          p;
        int          gap;
        crc = fcs_of();
        for (int i = 0; i < 4; i++) frame_q.push_back(crc[8*i +: 8]);
        if (kind == "B") frame_q[20] = frame_q[20] ^ 8'h01;
        if (kind == "E") frame_q[10] = 8'hFE;
        n = frame_q.size();
        // Expected beats, four bytes each, last keep from the remainder
        for (int b = 0; b < (n + 3) / 4; b++) begin
            d = '0;
            k = '0;
            for (int l = 0; l < 4; l++) begin
                if (4 * b + l < n) begin
                    d[8*l +: 8] = frame_q[4*b + l];
                    k[l] = 1'b1;
                end
            end
            exp_data.push_back(d);
            exp_keep.push_back(k);
            exp_last.push_back(b == (n + 3) / 4 - 1);
            // Error flag only on the last beat
            exp_user.push_back((kind == "B" || kind == "E") && b == (n + 3) / 4 - 1);
        end
        exp_start++;
        if (kind == "B") exp_fcs++;
        if (kind == "E") exp_frame++;
        drive_word(32'h555555FB, 4'b0001);
        drive_word(32'hD5555555, 4'b0000);
        for (int w = 0; w <= n / 4; w++) begin
            for (int l = 0; l < 4; l++) begin
                p = 4 * w + l;
                if (p < n) begin
                    d[8*l +: 8] = frame_q[p];
                    c[l] = (kind == "E" && p == 10);
                end else begin
                    d[8*l +: 8] = (p == n) ? 8'hFD : 8'h07;
                    c[l] = 1'b1;
                end
            end
            drive_word(d, c);
        end
        gap = 1 + ($unsigned($random(seed)) % 4);
        repeat (gap) drive_word(32'h07070707, 4'hF);
    endtask

    // Ack responder, two cycles behind req in both directions
    initial begin
        rx_lfc_ack = 1'b0;
        forever begin
            @(posedge rx_clk);
            if (rx_lfc_req && !rx_lfc_ack) begin
                repeat (2) @(posedge rx_clk);
                #1 rx_lfc_ack = 1'b1;
            end else if (!rx_lfc_req && rx_lfc_ack) begin
                repeat (2) @(posedge rx_clk);
                #1 rx_lfc_ack = 1'b0;
            end
        end
    end

    always @(posedge rx_clk) begin
        cyc++;
        if (cyc > limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output monitor, sampled on the falling edge
    always @(negedge rx_clk) begin
        if (!rx_rst) begin
            if (m_axis_rx_tvalid) begin
                if (exp_data.size() == 0) begin
                    $display("error: output beat arrived with none expected");
                    err_count++;
                end else begin
                    for (int l = 0; l < 4; l++) mask[8*l +: 8] = {8{exp_keep[0][l]}};
                    check("beat_data", exp_data[0], m_axis_rx_tdata & mask);
                    check("beat_keep", exp_keep[0], m_axis_rx_tkeep);
                    check("beat_last", exp_last[0], m_axis_rx_tlast);
                    check("beat_user", exp_user[0], m_axis_rx_tuser);
                    void'(exp_data.pop_front());
                    void'(exp_keep.pop_front());
                    void'(exp_last.pop_front());
                    void'(exp_user.pop_front());
                    beat_count++;
                end
                if (m_axis_rx_tlast) last_end = cyc;
            end
            // Error pulses belong to the last beat of their frame
            if ((rx_error_bad_fcs || rx_error_bad_frame) &&
                !(m_axis_rx_tvalid && m_axis_rx_tlast)) begin
                $display("error: bad frame or bad FCS pulse away from a last beat");
                err_count++;
            end
            n_start  += rx_start_packet;
            n_fcs    += rx_error_bad_fcs;
            n_frame  += rx_error_bad_frame;
            n_mcf    += stat_rx_mcf;
            n_pkt    += stat_rx_lfc_pkt;
            n_xon    += stat_rx_lfc_xon;
            n_xoff   += stat_rx_lfc_xoff;
            n_paused += stat_rx_lfc_paused && rx_lfc_ack;
            // Pause length measured from the last beat of the starting frame
            if (rx_lfc_req && !prev_req) begin
                start_ref = last_end;
                if (req_min.size() == 0) begin
                    $display("error: rx_lfc_req rose with no pause expected");
                    err_count++;
                end
            end
            if (!rx_lfc_req && prev_req && req_min.size() != 0) begin
                if (cyc - start_ref < req_min[0] || cyc - start_ref > req_max[0]) begin
                    $display("error: rx_lfc_req held %0d cycles, outside %0d to %0d",
                             cyc - start_ref, req_min[0], req_max[0]);
                    err_count++;
                end
                void'(req_min.pop_front());
                void'(req_max.pop_front());
            end
            prev_req = rx_lfc_req;
        end
    end

    initial begin
        int  fd;
        int  r;
        int  a;
        int  b;
        int  c;
        int  words;
        int  quanta_sum;
        byte cmd;
        logic [8*200-1:0] line;
        rx_clk        = 1'b0;
        rx_rst        = 1'b1;
        xgmii_rxd     = 32'h07070707;
        xgmii_rxc     = 4'hF;
        cfg_rx_lfc_en = 1'b0;
        words         = 0;
        quanta_sum    = 0;

        fd = $fopen("test/rx_trace.txt", "r");
        if (fd == 0) begin
            $display("error: could not open test/rx_trace.txt");
            err_count++;
        end else begin
            while (!$feof(fd)) begin
                cmd = 0;
                r = $fscanf(fd, " %c", cmd);
                if (r == 1 && cmd == "#") begin
                    r = $fgets(line, fd);
                end else if (r == 1 && cmd == "R") begin
                    r = $fscanf(fd, " %d %d", a, b);
                    req_min.push_back(a);
                    req_max.push_back(b);
                end else if (r == 1) begin
                    r = $fscanf(fd, " %h %h %h", a, b, c);
                    cmd_q.push_back(cmd);
                    a_q.push_back(a);
                    b_q.push_back(b);
                    c_q.push_back(c);
                    if (cmd == "P") begin
                        words += 28 + c;
                        quanta_sum += a;
                    end else begin
                        words += 12 + (a + 4) / 4;
                    end
                end
            end
            $fclose(fd);
        end
        limit = 2 * words + quanta_sum * 16 + 200;

        repeat (4) @(posedge rx_clk);
        #1 rx_rst = 1'b0;
        repeat (4) drive_word(32'h07070707, 4'hF);

        foreach (cmd_q[i]) begin
            frame_q = {};
            if (cmd_q[i] == "P") begin
                // PAUSE: reserved multicast, fixed source, type 8808, opcode 0001
                frame_q = '{8'h01, 8'h80, 8'hC2, 8'h00, 8'h00, 8'h01,
                            8'h00, 8'h11, 8'h22, 8'h33, 8'h44, 8'h55,
                            8'h88, 8'h08, 8'h00, 8'h01};
                frame_q.push_back(a_q[i][15:8]);
                frame_q.push_back(a_q[i][7:0]);
                while (frame_q.size() < 60) frame_q.push_back(8'h00);
                cfg_rx_lfc_en = b_q[i][0];
                exp_mcf++;
                if (a_q[i] == 0) exp_xon++;
                else exp_xoff++;
                send_frame("P");
                repeat (c_q[i]) drive_word(32'h07070707, 4'hF);
            end else begin
                for (int j = 0; j < a_q[i]; j++) frame_q.push_back(8'(b_q[i] + j));
                send_frame(cmd_q[i]);
            end
        end
        repeat (40) drive_word(32'h07070707, 4'hF);

        if (exp_data.size() != 0) begin
            $display("error: %0d expected beats never arrived", exp_data.size());
            err_count++;
        end
        if (req_min.size() != 0) begin
            $display("error: %0d expected pause requests never ended", req_min.size());
            err_count++;
        end
        check("start_packets", exp_start, n_start);
        check("bad_fcs_pulses", exp_fcs, n_fcs);
        check("bad_frame_pulses", exp_frame, n_frame);
        check("mcf_pulses", exp_mcf, n_mcf);
        check("lfc_pkt_pulses", exp_mcf, n_pkt);
        check("lfc_xon_pulses", exp_xon, n_xon);
        check("lfc_xoff_pulses", exp_xoff, n_xoff);
        check("paused_seen", 1, n_paused > 0);

        $display("errors %0d, beats checked %0d, cycles %0d", err_count, beat_count, cyc);
        if (err_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/rx_trace.txt
# G/B/E <payload bytes hex> <first byte hex> <unused>: good, bad FCS, error character
# P <quanta hex> <cfg_rx_lfc_en> <idle words after, hex>; R <min> <max>: req cycles
G 3c 10 0
G 3d 20 0
G 3e 30 0
G 3f 40 0
G 40 50 0
G 64 60 0
G 5b a0 0
# Flipped payload bit
B 40 70 0
# Error character at byte 10
E 46 80 0
G 3c 90 0
# PAUSE of 16 quanta runs to its end
P 0010 1 12c
R 256 264
# PAUSE of 64 quanta cut short by quanta 0
P 0040 1 0
P 0000 1 64
R 0 200
# Pausing disabled, statistics only
P 0010 0 64
G 3d c0 0

// File: src.f
verilog/mac_rx_pkg.sv
verilog/xgmii_rx_decode.sv
verilog/rx_fcs_check.sv
verilog/mcf_rx_parse.sv
verilog/lfc_pause_rx.sv
verilog/eth_mac_rx.sv
test/eth_mac_rx_assert.sv
test/tb_eth_mac_rx.sv
